/* src.f */
+incdir+test
design/uart_pkg.sv
design/baud_tick_gen.sv
design/uart_tx.sv
design/uart_rx.sv
design/rx_fifo.sv
design/uart_top.sv
test/tb_uart.sv

/* run.sh */
#!/bin/sh
# build the uart testbench with verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_uart -f src.f -o tb_uart_sim \
	|| { echo "verilator build failed"; exit 1; }
./obj_dir/tb_uart_sim > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "all tests passed" sim.log || { echo "FAIL, run ended early"; exit 1; }
echo "PASS"

/* test/tb_uart_model.svh */
`ifndef TB_UART_MODEL_SVH
`define TB_UART_MODEL_SVH

logic [31:0] rng_state = 32'd85445;  // lcg state, fixed seed
logic [DW:0] exp_q[$];               // expected fifo entries, error flag above the word

// plain 32 bit lcg
function automatic logic [31:0] lcg_next();
	rng_state = rng_state * 32'd1103515245 + 32'd12345;
	return rng_state;
endfunction

function automatic logic [DW-1:0] rand_word();
	logic [31:0] r;
	r = lcg_next();
	return r[16 +: DW];  // upper bits, low lcg bits repeat quickly
endfunction

function automatic int rand_gap();
	logic [31:0] r;
	r = lcg_next();
	return int'(r[26:24]);  // 0 to 7 idle cycles
endfunction

// line level of bit idx in a frame: start, data lsb first, even parity, stop
function automatic logic frame_bit(input logic [DW-1:0] data, input int idx);
	if (idx == 0) begin
		return 1'b0;
	end else if (idx <= DW) begin
		return data[idx-1];
	end else if (idx == DW + 1) begin
		return ^data;  // even parity, xor of the data
	end
	return 1'b1;
endfunction

task automatic push_expected(input logic [DW-1:0] data, input logic err);
	exp_q.push_back({err, data});
endtask

task automatic check_value(input logic [31:0] got, input logic [31:0] want, input string what);
	if (got !== want) begin
		$display("Mismatch at time %0t: %s, got %0h, expected %0h", $time, what, got, want);
		$display("tests failed");
		$fatal(1, "value check failed");
	end
endtask

`endif

/* test/tb_uart.sv */
`default_nettype none

module tb_uart;

	import uart_pkg::*;

	localparam int DW          = DEF_DATA_WIDTH;
	localparam int CPB         = DEF_CLOCKS_PER_BIT;
	localparam int FD          = DEF_FIFO_DEPTH;
	localparam int F           = DW + 3;  // start, data, parity, stop
	localparam int CLK_PERIOD  = 8;
	localparam int N_LOOP      = 40;      // random loopback words
	localparam int N_CHAIN     = 6;       // back to back words
	localparam int N_INJECT    = 6;       // frames bit-banged on the external line
	localparam int N_FRAMES    = 1 + N_LOOP + N_CHAIN + N_INJECT + FD + 2;
	localparam int CYCLE_LIMIT = (N_FRAMES + 4) * F * CPB * 2;

	logic          clk;
	logic          reset;
	logic          enable;
	logic [DW-1:0] tx_data;
	logic          loopback;
	logic          ext_serial;  // external line into the receiver
	logic          rd;
	logic          busy;
	logic          tx_line;
	logic [DW-1:0] rd_data;
	logic          rd_err;
	logic          empty;
	logic          overflow;
	bit            auto_read;        // consumer pops whenever an entry shows up
	int            cycle_count = 0;

	`include "tb_uart_model.svh"

	uart_top #(
		.DATA_WIDTH     (DW),
		.CLOCKS_PER_BIT (CPB),
		.PARITY         (PARITY_EVEN),
		.FIFO_DEPTH     (FD)
	) dut (
		.clk        (clk),
		.reset      (reset),
		.i_enable   (enable),
		.i_data     (tx_data),
		.i_loopback (loopback),
		.i_serial   (ext_serial),
		.i_rd       (rd),
		.o_busy     (busy),
		.o_serial   (tx_line),
		.o_rd_data  (rd_data),
		.o_rd_err   (rd_err),
		.o_empty    (empty),
		.o_overflow (overflow)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout, run went past %0d clock cycles", CYCLE_LIMIT);
			$display("tests failed");
			$fatal(1, "simulation timed out");
		end
	end

	// one clock that optionally pops and checks the fifo head on the way
	task automatic advance_cycle();
		logic [DW:0] head;
		if (auto_read) begin
			if (!empty && (exp_q.size() == 0)) begin
				$display("receive FIFO holds an entry that was never sent, time %0t", $time);
				$display("tests failed");
				$fatal(1, "unexpected receive entry");
			end else if (!empty) begin
				head = exp_q.pop_front();
				check_value(32'(rd_data), 32'(head[DW-1:0]), "received word");
				check_value(32'(rd_err), 32'(head[DW]), "received error flag");
				rd = 1'b1;
			end else begin
				rd = 1'b0;
			end
		end
		@(posedge clk);
		#1;  // drive and sample just after the edge
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0) begin
			advance_cycle();
		end
	endtask

	task automatic send_word(input logic [DW-1:0] word);
		while (busy) begin
			advance_cycle();
		end
		tx_data = word;
		enable  = 1'b1;
		advance_cycle();  // taken at this edge
		enable  = 1'b0;
	endtask

	// receiver reports within SYNC_STAGES+1 cycles of mid stop so one bit time is plenty
	task automatic settle_rx();
		while (busy) begin
			advance_cycle();
		end
		repeat (CPB) advance_cycle();
	endtask

	task automatic inject_frame(input logic [DW-1:0] data, input logic flip_par,
				    input logic stop_val);
		logic [F-1:0] bits;
		bits[0]      = 1'b0;
		bits[DW:1]   = data;
		bits[DW+1]   = (^data) ^ flip_par;  // even parity unless flipped
		bits[DW+2]   = stop_val;
		for (int b = 0; b < F; b++) begin
			ext_serial = bits[b];
			repeat (CPB) advance_cycle();
		end
		ext_serial = 1'b1;
		repeat (CPB) advance_cycle();  // one idle bit so the next start edge is seen
	endtask

	initial begin
		logic [DW-1:0] word;
		logic          flip;
		logic          stop;
		int            spacing;
		clk        = 1'b0;
		reset      = 1'b1;
		enable     = 1'b0;
		tx_data    = '0;
		loopback   = 1'b1;
		ext_serial = 1'b1;  // idle line
		rd         = 1'b0;
		auto_read  = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		check_value(32'(busy), 32'd0, "busy after reset");
		check_value(32'(overflow), 32'd0, "overflow after reset");
		check_value(32'(empty), 32'd1, "empty after reset");
		check_value(32'(tx_line), 32'd1, "line after reset");

		// frame timing checked bit by bit on o_serial
		word = rand_word();
		push_expected(word, 1'b0);
		tx_data = word;
		enable  = 1'b1;
		advance_cycle();
		enable  = 1'b0;
		tx_data = ~word;  // captured copy must be used
		for (int b = 0; b < F; b++) begin
			for (int c = 0; c < CPB; c++) begin
				check_value(32'(busy), 32'd1, "busy during frame");
				check_value(32'(tx_line), 32'(frame_bit(word, b)),
					    $sformatf("serial bit %0d", b));
				advance_cycle();
			end
		end
		check_value(32'(busy), 32'd0, "busy after stop bit");
		check_value(32'(tx_line), 32'd1, "line after stop bit");
		wait_drained();

		// random loopback words sent one frame at a time
		for (int k = 0; k < N_LOOP; k++) begin
			word = rand_word();
			push_expected(word, 1'b0);
			send_word(word);
			wait_drained();
			repeat (rand_gap()) advance_cycle();
		end

		// enable held high so frames chain after a single idle cycle
		enable = 1'b1;
		for (int k = 0; k < N_CHAIN; k++) begin
			word    = rand_word();
			tx_data = word;  // previous word is already in the shift register
			push_expected(word, 1'b0);
			spacing = 0;
			while (busy) begin
				advance_cycle();
				spacing++;
			end
			advance_cycle();
			spacing++;
			check_value(32'(busy), 32'd1, "busy after chained enable");
			if (k > 0) begin
				check_value(32'(spacing), 32'(F * CPB + 1), "spacing of chained frames");
			end
		end
		enable = 1'b0;
		wait_drained();

		// bad parity and low stop bits on the external line
		while (busy) begin
			advance_cycle();
		end
		loopback = 1'b0;
		for (int k = 0; k < N_INJECT; k++) begin
			word = rand_word();
			flip = (k == 1) || (k == 4);
			stop = !((k == 3) || (k == 4));
			push_expected(word, flip || !stop);
			inject_frame(word, flip, stop);
			wait_drained();
		end
		loopback = 1'b1;

		// fill past depth with no reads
		auto_read = 1'b0;
		rd        = 1'b0;
		for (int k = 0; k < FD + 2; k++) begin
			word = rand_word();
			if (k < FD) begin
				push_expected(word, 1'b0);  // later words hit a full fifo
			end
			send_word(word);
			if (k == FD - 1) begin
				settle_rx();
				check_value(32'(overflow), 32'd0, "overflow with fifo just full");
				check_value(32'(empty), 32'd0, "empty with fifo full");
			end
		end
		settle_rx();
		check_value(32'(overflow), 32'd1, "overflow after dropped frames");
		auto_read = 1'b1;
		wait_drained();
		auto_read = 1'b0;
		rd        = 1'b0;
		check_value(32'(empty), 32'd1, "empty after drain");
		rd = 1'b1;  // pop on an empty fifo
		advance_cycle();
		rd = 1'b0;
		check_value(32'(empty), 32'd1, "empty after read on empty");
		advance_cycle();
		check_value(32'(empty), 32'd1, "empty one cycle later");
		check_value(32'(overflow), 32'd1, "overflow stays set");

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* design/uart_top.sv */
`default_nettype none

module uart_top #(
	parameter int                     DATA_WIDTH     = uart_pkg::DEF_DATA_WIDTH,
	parameter int                     CLOCKS_PER_BIT = uart_pkg::DEF_CLOCKS_PER_BIT,
	parameter uart_pkg::parity_mode_t PARITY         = uart_pkg::PARITY_EVEN,
	parameter int                     FIFO_DEPTH     = uart_pkg::DEF_FIFO_DEPTH
) (
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  i_enable,    // transmit request
	input  wire [DATA_WIDTH-1:0] i_data,      // transmit word
	input  wire                  i_loopback,  // 1 feeds tx back into rx
	input  wire                  i_serial,    // external line into rx
	input  wire                  i_rd,        // pop one received entry
	output wire                  o_busy,
	output wire                  o_serial,    // tx line, also in loopback
	output wire [DATA_WIDTH-1:0] o_rd_data,
	output wire                  o_rd_err,
	output wire                  o_empty,
	output wire                  o_overflow
);

	logic                  tx_serial;    // transmitter line
	logic                  rx_serial;    // receiver line after the mux
	logic                  frame_valid;  // receiver to fifo strobe
	logic [DATA_WIDTH-1:0] frame_data;
	logic                  frame_error;

	assign rx_serial = i_loopback ? tx_serial : i_serial;
	assign o_serial  = tx_serial;

	uart_tx #(
		.DATA_WIDTH     (DATA_WIDTH),
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT),
		.PARITY         (PARITY)
	) u_tx (
		.clk      (clk),
		.reset    (reset),
		.i_enable (i_enable),
		.i_data   (i_data),
		.o_busy   (o_busy),
		.o_serial (tx_serial)
	);

	uart_rx #(
		.DATA_WIDTH     (DATA_WIDTH),
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT),
		.PARITY         (PARITY)
	) u_rx (
		.clk           (clk),
		.reset         (reset),
		.i_serial      (rx_serial),
		.o_frame_valid (frame_valid),
		.o_frame_data  (frame_data),
		.o_frame_error (frame_error)
	);

	rx_fifo #(
		.DATA_WIDTH (DATA_WIDTH),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk        (clk),
		.reset      (reset),
		.i_wr       (frame_valid),
		.i_wr_data  (frame_data),
		.i_wr_err   (frame_error),
		.i_rd       (i_rd),
		.o_rd_data  (o_rd_data),
		.o_rd_err   (o_rd_err),
		.o_empty    (o_empty),
		.o_overflow (o_overflow)
	);

endmodule

`default_nettype wire

/* design/rx_fifo.sv */
`default_nettype none

module rx_fifo #(
	parameter int DATA_WIDTH = uart_pkg::DEF_DATA_WIDTH,
	parameter int FIFO_DEPTH = uart_pkg::DEF_FIFO_DEPTH
) (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   i_wr,        // frame strobe from the receiver
	input  wire  [DATA_WIDTH-1:0] i_wr_data,
	input  wire                   i_wr_err,
	input  wire                   i_rd,        // consumer pops the head
	output logic [DATA_WIDTH-1:0] o_rd_data,   // head word, valid while not empty
	output logic                  o_rd_err,
	output logic                  o_empty,
	output logic                  o_overflow   // sticky until reset
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	logic [DATA_WIDTH:0] mem [FIFO_DEPTH];  // error flag kept above the word
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [PTR_W:0]      count;   // entries held, 0 to FIFO_DEPTH
	logic                full;
	logic                do_rd;
	logic                do_wr;

	assign full    = (count == (PTR_W + 1)'(FIFO_DEPTH));
	assign o_empty = (count == '0);
	assign do_rd   = i_rd && !o_empty;       // pop on empty is ignored
	assign do_wr   = i_wr && (!full || do_rd);  // full plus pop still takes the write

	assign o_rd_data = mem[rd_ptr][DATA_WIDTH-1:0];
	assign o_rd_err  = mem[rd_ptr][DATA_WIDTH];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= {i_wr_err, i_wr_data};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			o_overflow <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, wraps itself
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
			if (i_wr && !do_wr) begin
				o_overflow <= 1'b1;  // frame lost, nothing pushes back on the receiver
			end
		end
	end

endmodule

`default_nettype wire

/* design/uart_rx.sv */
`default_nettype none

module uart_rx #(
	parameter int                     DATA_WIDTH     = uart_pkg::DEF_DATA_WIDTH,
	parameter int                     CLOCKS_PER_BIT = uart_pkg::DEF_CLOCKS_PER_BIT,
	parameter uart_pkg::parity_mode_t PARITY         = uart_pkg::PARITY_EVEN
) (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   i_serial,       // asynchronous line
	output logic                  o_frame_valid,  // one cycle, mid stop bit
	output logic [DATA_WIDTH-1:0] o_frame_data,
	output logic                  o_frame_error   // parity mismatch or low stop bit
);

	import uart_pkg::*;

	localparam int IDX_W = (DATA_WIDTH > 2) ? $clog2(DATA_WIDTH) : 1;

	typedef enum logic [2:0] {
		ST_IDLE,    // waiting for a falling edge
		ST_START,   // confirming the start bit
		ST_DATA,    // shifting in data bits
		ST_PARITY,  // checking parity
		ST_STOP     // checking stop, frame ends here
	} rx_state_t;

	rx_state_t              state;
	logic [SYNC_STAGES-1:0] sync_q;      // bit 0 is the first flop
	logic                   line;        // synchronized line
	logic                   line_q;      // line one cycle back, for edge detect
	logic                   start_edge;  // high to low while idle
	logic                   mid_bit;     // sampling tick
	logic [DATA_WIDTH-1:0]  data_q;      // assembled word, lsb arrives first
	logic [IDX_W-1:0]       bit_idx;     // data bit being sampled
	logic                   par_err;     // sticky for the current frame
	logic                   last_data;

	assign line       = sync_q[SYNC_STAGES-1];
	assign start_edge = (state == ST_IDLE) && line_q && !line;
	assign last_data  = (bit_idx == IDX_W'(DATA_WIDTH - 1));

	// frame handed out at the stop sample, no extra register stage
	assign o_frame_valid = (state == ST_STOP) && mid_bit;
	assign o_frame_data  = data_q;
	assign o_frame_error = par_err || !line;  // line holds the stop bit here

	baud_tick_gen #(
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT)
	) u_ticks (
		.clk       (clk),
		.reset     (reset),
		.i_restart (start_edge),  // align sampling to the start bit
		.o_bit_end (),            // bit boundaries are not needed here
		.o_mid_bit (mid_bit)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q <= '1;  // idle level, no false start after reset
			line_q <= 1'b1;
		end else begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], i_serial};
			line_q <= line;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= ST_IDLE;
			bit_idx <= '0;
			par_err <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start_edge) begin
						state <= ST_START;
					end
				end
				ST_START: begin
					if (mid_bit) begin
						if (line) begin
							state <= ST_IDLE;  // glitch, no frame reported
						end else begin
							state   <= ST_DATA;
							bit_idx <= '0;
							par_err <= 1'b0;
						end
					end
				end
				ST_DATA: begin
					if (mid_bit) begin
						bit_idx <= bit_idx + 1'b1;
						if (last_data) begin
							state <= (PARITY == PARITY_NONE) ? ST_STOP : ST_PARITY;
						end
					end
				end
				ST_PARITY: begin
					if (mid_bit) begin
						par_err <= (line != parity_bit(^data_q, PARITY));
						state   <= ST_STOP;
					end
				end
				ST_STOP: begin
					if (mid_bit) begin
						state <= ST_IDLE;  // next falling edge starts a new frame
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == ST_DATA) && mid_bit) begin
			data_q <= {line, data_q[DATA_WIDTH-1:1]};  // lsb first, shifts down
		end
	end

endmodule

`default_nettype wire

/* design/uart_tx.sv */
`default_nettype none

module uart_tx #(
	parameter int                     DATA_WIDTH     = uart_pkg::DEF_DATA_WIDTH,
	parameter int                     CLOCKS_PER_BIT = uart_pkg::DEF_CLOCKS_PER_BIT,
	parameter uart_pkg::parity_mode_t PARITY         = uart_pkg::PARITY_EVEN
) (
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  i_enable,  // start request, looked at only while idle
	input  wire [DATA_WIDTH-1:0] i_data,    // word, captured with the request
	output logic                 o_busy,    // frame in progress
	output logic                 o_serial   // line, high when idle
);

	import uart_pkg::*;

	localparam int FRAME_BITS = frame_bits(DATA_WIDTH, PARITY);
	localparam int CNT_W      = $clog2(FRAME_BITS);

	logic [FRAME_BITS-1:0] frame_word;  // next frame, lsb goes out first
	logic [FRAME_BITS-1:0] shift_q;     // bit 0 drives the line
	logic [CNT_W-1:0]      bit_cnt;     // bits finished in this frame
	logic                  accept;      // request taken at this edge
	logic                  bit_end;     // current bit has run its full period
	logic                  last_bit;

	assign accept   = i_enable && !o_busy;
	assign last_bit = (bit_cnt == CNT_W'(FRAME_BITS - 1));  // stop bit on the line
	assign o_serial = shift_q[0];

	// frame layout from bit 0 upward: start, data lsb first, parity, stop
	always_comb begin
		frame_word               = '1;    // stop bit and idle level
		frame_word[0]            = 1'b0;  // start
		frame_word[DATA_WIDTH:1] = i_data;
		if (PARITY != PARITY_NONE) begin
			frame_word[DATA_WIDTH+1] = parity_bit(^i_data, PARITY);
		end
	end

	// bit timing restarts with every accepted frame
	baud_tick_gen #(
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT)
	) u_ticks (
		.clk       (clk),
		.reset     (reset),
		.i_restart (accept),
		.o_bit_end (bit_end),
		.o_mid_bit ()  // only the receiver samples mid-bit
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			o_busy  <= 1'b0;
			bit_cnt <= '0;
			shift_q <= '1;  // line idles high out of reset
		end else if (!o_busy) begin
			if (accept) begin
				o_busy  <= 1'b1;        // high together with the start bit
				shift_q <= frame_word;  // data is safe to change after this
				bit_cnt <= '0;
			end
		end else if (bit_end) begin
			shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};  // ones fill in behind the stop bit
			if (last_bit) begin
				o_busy  <= 1'b0;  // stop bit done, line stays high
				bit_cnt <= '0;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/baud_tick_gen.sv */
`default_nettype none

module baud_tick_gen #(
	parameter int CLOCKS_PER_BIT = uart_pkg::DEF_CLOCKS_PER_BIT
) (
	input  wire  clk,
	input  wire  reset,
	input  wire  i_restart,  // realign the bit period to this edge
	output logic o_bit_end,  // last cycle of the bit period
	output logic o_mid_bit   // sampling point of the bit period
);

	localparam int CNT_W = (CLOCKS_PER_BIT > 2) ? $clog2(CLOCKS_PER_BIT) : 1;

	logic [CNT_W-1:0] cnt;  // position inside the current bit

	assign o_bit_end = (cnt == CNT_W'(CLOCKS_PER_BIT - 1));
	assign o_mid_bit = (cnt == CNT_W'(CLOCKS_PER_BIT / 2));

	always_ff @(posedge clk) begin
		if (reset || i_restart) begin
			cnt <= '0;  // count 0 is the first cycle of a bit
		end else if (o_bit_end) begin
			cnt <= '0;  // wrap, also for non power of two periods
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* design/uart_pkg.sv */
`default_nettype none

package uart_pkg;

	localparam int DEF_DATA_WIDTH     = 8;  // data bits per frame
	localparam int DEF_CLOCKS_PER_BIT = 8;  // clk cycles per serial bit
	localparam int DEF_FIFO_DEPTH     = 4;  // rx fifo entries, keep a power of two

	localparam int SYNC_STAGES = 3;  // flops between the pin and the rx fsm

	// parity field of the frame
	typedef enum logic [1:0] {
		PARITY_NONE = 2'd0,  // no parity bit sent
		PARITY_EVEN = 2'd1,  // bit equals xor of the data
		PARITY_ODD  = 2'd2   // bit equals inverted xor of the data
	} parity_mode_t;

	// total bits on the line: start, data, optional parity, one stop
	function automatic int frame_bits(input int data_width, input parity_mode_t parity);
		int bits;
		bits = data_width + 2;  // start and stop
		if (parity != PARITY_NONE) begin
			bits = bits + 1;  // room for the parity bit
		end
		return bits;
	endfunction

	// expected parity bit from the xor of the data bits
	function automatic logic parity_bit(input logic data_xor, input parity_mode_t parity);
		logic bit_val;
		bit_val = data_xor;
		if (parity == PARITY_ODD) begin
			bit_val = ~data_xor;  // odd mode inverts
		end
		return bit_val;
	endfunction

endpackage

`default_nettype wire
